// ==== lu_engine.f ====
common/lu_num_pkg.sv
common/lu_ctrl_pkg.sv
src/complex_mul.sv
lu/complex_recip.sv
lu/lu_step.sv
src/row_store.sv
src/lu_engine.sv
sim/tb_clock.sv
sim/lu_engine_tb.sv

// ==== Bender.yml ====
package:
  name: lu_engine

sources:
  - common/lu_num_pkg.sv
  - common/lu_ctrl_pkg.sv
  - src/complex_mul.sv
  - lu/complex_recip.sv
  - lu/lu_step.sv
  - src/row_store.sv
  - src/lu_engine.sv
  - target: simulation
    files:
      - sim/tb_clock.sv
      - sim/lu_engine_tb.sv

// ==== sim/lu_engine_tb.sv ====
module lu_engine_tb;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int          N              = lu_ctrl_pkg::MAT_N;
  localparam int          FB             = lu_num_pkg::FRAC_BITS;
  localparam logic [31:0] SEED           = 32'hce53_b281;
  localparam int          RESET_TIMEOUT  = 50;
  localparam int          RUN_TIMEOUT    = 5000;
  localparam int          CREDIT_TIMEOUT = 2000;
  localparam int          HOLD_CYCLES    = 150;

  logic                   clk, rst_n;
  logic                   load_valid, start, res_credit;
  lu_ctrl_pkg::row_addr_t load_addr, res_step;
  lu_ctrl_pkg::row_t      load_row, res_l_col, res_u_row;
  logic                   res_valid, busy, done;

  lu_ctrl_pkg::row_t mat [N];
  lu_ctrl_pkg::row_t exp_l [N]; // expected results per step
  lu_ctrl_pkg::row_t exp_u [N];
  logic [31:0]       rng_q;
  logic              hold_credits, started;
  int                res_cnt, outstanding;

  tb_clock u_clock (
    .clk_o  (clk),
    .rst_no (rst_n)
  );

  lu_engine UUT (
    .clk_i        (clk),
    .rst_ni       (rst_n),
    .load_valid_i (load_valid),
    .load_addr_i  (load_addr),
    .load_row_i   (load_row),
    .start_i      (start),
    .res_valid_o  (res_valid),
    .res_step_o   (res_step),
    .res_l_col_o  (res_l_col),
    .res_u_row_o  (res_u_row),
    .res_credit_i (res_credit),
    .busy_o       (busy),
    .done_o       (done)
  );

  function automatic logic [31:0] xorshift32(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  function automatic longint re_of(input lu_num_pkg::cplx_t c);
    return lu_num_pkg::part_t'(c[15:0]);
  endfunction

  function automatic longint im_of(input lu_num_pkg::cplx_t c);
    return lu_num_pkg::part_t'(c[31:16]);
  endfunction

  function automatic lu_num_pkg::cplx_t pack_cplx(input longint re, input longint im);
    return {im[15:0], re[15:0]}; // parts wrap to 16 bits
  endfunction

  // floor after the shift
  function automatic lu_num_pkg::cplx_t fx_mul(input lu_num_pkg::cplx_t a,
                                               input lu_num_pkg::cplx_t b);
    longint re, im;
    re = (re_of(a) * re_of(b) - im_of(a) * im_of(b)) >>> FB;
    im = (re_of(a) * im_of(b) + im_of(a) * re_of(b)) >>> FB;
    return pack_cplx(re, im);
  endfunction

  // conj(p) / |p|^2 with quotients truncated toward zero
  function automatic lu_num_pkg::cplx_t fx_recip(input lu_num_pkg::cplx_t p);
    longint den;
    den = (re_of(p) * re_of(p) + im_of(p) * im_of(p)) >>> FB;
    return pack_cplx((re_of(p) <<< FB) / den, (-im_of(p) <<< FB) / den);
  endfunction

  function automatic lu_num_pkg::cplx_t fx_sub(input lu_num_pkg::cplx_t a,
                                               input lu_num_pkg::cplx_t b);
    return pack_cplx(re_of(a) - re_of(b), im_of(a) - im_of(b));
  endfunction

  function automatic string value_error(input string what, input int step,
                                        input lu_ctrl_pkg::row_t got,
                                        input lu_ctrl_pkg::row_t want);
    return $sformatf("** Error at %0d ns: step %0d %s is %h, expected %h",
                     $time, step, what, got, want);
  endfunction

  task automatic stop_with_failure(input string line);
    $display("%s", line);
    $display("Simulation failed");
    $fatal(1, "stopping at the first failure");
  endtask

  task automatic build_expected();
    lu_ctrl_pkg::row_t work [N];
    lu_ctrl_pkg::row_t u, l;
    lu_num_pkg::cplx_t r, m;
    work = mat;
    for (int k = 0; k < N; k++) begin
      for (int j = 0; j < N; j++) begin
        u[j] = (j < k) ? '0 : work[k][j];
        l[j] = (j == k) ? lu_num_pkg::CPLX_ONE : '0;
      end
      if (k < N - 1) begin
        r = fx_recip(work[k][k]);
        for (int i = k + 1; i < N; i++) begin
          m    = fx_mul(work[i][k], r);
          l[i] = m;
          for (int j = 0; j < N; j++) begin
            work[i][j] = fx_sub(work[i][j], fx_mul(m, u[j]));
          end
        end
      end
      exp_l[k] = l;
      exp_u[k] = u;
    end
  endtask

  task automatic identity_matrix();
    for (int r = 0; r < N; r++) begin
      for (int j = 0; j < N; j++) begin
        mat[r][j] = (r == j) ? lu_num_pkg::CPLX_ONE : '0;
      end
    end
  endtask

  // small entries with the diagonal between 2.0 and 3.0
  task automatic random_matrix();
    lu_num_pkg::part_t re, im;
    for (int r = 0; r < N; r++) begin
      for (int j = 0; j < N; j++) begin
        rng_q = xorshift32(rng_q);
        re    = lu_num_pkg::part_t'($signed(rng_q[10:0]));
        im    = lu_num_pkg::part_t'($signed(rng_q[26:16]));
        if (r == j) re = 16'(8192 + rng_q[11:0]);
        mat[r][j] = {im, re};
      end
    end
  endtask

  task automatic load_matrix();
    for (int r = 0; r < N; r++) begin
      load_valid <= 1'b1;
      load_addr  <= lu_ctrl_pkg::row_addr_t'(r);
      load_row   <= mat[r];
      @(posedge clk);
    end
    load_valid <= 1'b0;
  endtask

  task automatic wait_outstanding(input int target, input string what);
    int cnt;
    cnt = 0;
    while (outstanding != target && cnt < CREDIT_TIMEOUT) begin
      @(posedge clk);
      cnt++;
    end
    if (outstanding != target) stop_with_failure({"timeout waiting for ", what});
  endtask

  task automatic run_matrix(input logic hold);
    int cnt;
    build_expected();
    load_matrix();
    hold_credits <= hold;
    start        <= 1'b1;
    @(posedge clk);
    start <= 1'b0;
    if (hold) begin
      wait_outstanding(lu_ctrl_pkg::RES_CREDITS, "the credit limit");
      repeat (HOLD_CYCLES) @(posedge clk); // stream stalls here
      hold_credits <= 1'b0;
    end
    cnt = 0;
    while (done !== 1'b1 && cnt < RUN_TIMEOUT) begin
      @(posedge clk);
      cnt++;
    end
    if (done !== 1'b1) stop_with_failure("timeout waiting for done after start");
  endtask

  always @(posedge clk) begin
    if (!rst_n) begin
      started     <= 1'b0;
      res_cnt     <= 0;
      outstanding <= 0;
    end else begin
      if (start) started <= 1'b1;
      if (start) res_cnt <= 0;
      else if (res_valid) res_cnt <= res_cnt + 1;
      case ({res_valid, res_credit})
        2'b10:   outstanding <= outstanding + 1;
        2'b01:   outstanding <= outstanding - 1;
        default: ;
      endcase
    end
  end

  // consumer retires one result at a time after a random delay
  initial begin : credit_return
    logic [31:0] rng;
    int          delay;
    rng        = ~SEED;
    res_credit = 1'b0;
    forever begin
      @(posedge clk);
      if (rst_n && !hold_credits && outstanding > 0) begin
        rng   = xorshift32(rng);
        delay = int'(rng[4:0]);
        repeat (delay) @(posedge clk);
        res_credit <= 1'b1;
        @(posedge clk);
        res_credit <= 1'b0;
      end
    end
  end

  a_idle_until_start : assert property (@(posedge clk) disable iff (!rst_n)
    !started |-> !res_valid && !busy && !done)
    else stop_with_failure($sformatf("** Error at %0d ns: outputs active before start",
                                     $time));

  a_busy_after_start : assert property (@(posedge clk) disable iff (!rst_n)
    start |=> busy)
    else stop_with_failure($sformatf("** Error at %0d ns: busy low after start", $time));

  a_step_order : assert property (@(posedge clk) disable iff (!rst_n)
    res_valid |-> busy && res_cnt < N && res_step == lu_ctrl_pkg::row_addr_t'(res_cnt))
    else stop_with_failure($sformatf("** Error at %0d ns: step %0d sent as result %0d",
                                     $time, $sampled(res_step), $sampled(res_cnt)));

  a_single_send : assert property (@(posedge clk) disable iff (!rst_n)
    res_valid |=> !res_valid)
    else stop_with_failure($sformatf("** Error at %0d ns: result held valid twice", $time));

  a_l_col : assert property (@(posedge clk) disable iff (!rst_n)
    res_valid |-> res_l_col == exp_l[res_step])
    else stop_with_failure(value_error("L column", $sampled(res_step),
                                       $sampled(res_l_col), exp_l[$sampled(res_step)]));

  a_u_row : assert property (@(posedge clk) disable iff (!rst_n)
    res_valid |-> res_u_row == exp_u[res_step])
    else stop_with_failure(value_error("U row", $sampled(res_step),
                                       $sampled(res_u_row), exp_u[$sampled(res_step)]));

  a_send_needs_credit : assert property (@(posedge clk) disable iff (!rst_n)
    res_valid |-> outstanding < lu_ctrl_pkg::RES_CREDITS)
    else stop_with_failure($sformatf("** Error at %0d ns: sent with %0d results outstanding",
                                     $time, $sampled(outstanding)));

  a_done_after_all : assert property (@(posedge clk) disable iff (!rst_n)
    done |-> res_cnt == N && !busy)
    else stop_with_failure($sformatf("** Error at %0d ns: done after %0d results, busy %b",
                                     $time, $sampled(res_cnt), $sampled(busy)));

  a_done_pulse : assert property (@(posedge clk) disable iff (!rst_n)
    done |=> !done)
    else stop_with_failure($sformatf("** Error at %0d ns: done longer than one cycle",
                                     $time));

  initial begin : stimulus
    int cnt;
    rng_q        = SEED;
    hold_credits = 1'b0;
    load_valid   = 1'b0;
    load_addr    = '0;
    load_row     = '0;
    start        = 1'b0;
    cnt          = 0;
    while (rst_n !== 1'b1 && cnt < RESET_TIMEOUT) begin
      @(posedge clk);
      cnt++;
    end
    if (rst_n !== 1'b1) stop_with_failure("timeout waiting for reset release");
    repeat (10) @(posedge clk); // idle window after reset
    identity_matrix();
    run_matrix(1'b0);
    random_matrix();
    run_matrix(1'b0);
    random_matrix();
    run_matrix(1'b1); // credits withheld
    random_matrix();
    run_matrix(1'b0);
    wait_outstanding(0, "the last credits");
    $display("Simulation completed successfully");
    $finish;
  end

endmodule

// ==== sim/tb_clock.sv ====
module tb_clock (
  output logic clk_o,
  output logic rst_no
);
  timeunit 1ns;
  timeprecision 1ps;

  localparam int HALF_PERIOD  = 50; // 100 ns clock
  localparam int RESET_CYCLES = 8;

  initial begin
    clk_o = 1'b0;
    forever #(HALF_PERIOD) clk_o = ~clk_o;
  end

  // released on a rising edge
  initial begin
    rst_no = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk_o);
    rst_no <= 1'b1;
  end

endmodule

// ==== src/lu_engine.sv ====
module lu_engine (
  input  logic                   clk_i,
  input  logic                   rst_ni,

  input  logic                   load_valid_i,
  input  lu_ctrl_pkg::row_addr_t load_addr_i,
  input  lu_ctrl_pkg::row_t      load_row_i,

  input  logic                   start_i,

  output logic                   res_valid_o,
  output lu_ctrl_pkg::row_addr_t res_step_o,
  output lu_ctrl_pkg::row_t      res_l_col_o,
  output lu_ctrl_pkg::row_t      res_u_row_o,
  input  logic                   res_credit_i,

  output logic                   busy_o,
  output logic                   done_o
);

  logic                   rd_en, wr_en;
  lu_ctrl_pkg::row_addr_t rd_addr, wr_addr;
  lu_ctrl_pkg::row_t      rd_row, wr_row;

  row_store u_store (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .load_valid_i (load_valid_i),
    .load_addr_i  (load_addr_i),
    .load_row_i   (load_row_i),
    .rd_en_i      (rd_en),
    .rd_addr_i    (rd_addr),
    .rd_row_o     (rd_row),
    .wr_en_i      (wr_en),
    .wr_addr_i    (wr_addr),
    .wr_row_i     (wr_row)
  );

  lu_step u_step (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .start_i      (start_i),
    .rd_en_o      (rd_en),
    .rd_addr_o    (rd_addr),
    .rd_row_i     (rd_row),
    .wr_en_o      (wr_en),
    .wr_addr_o    (wr_addr),
    .wr_row_o     (wr_row),
    .res_valid_o  (res_valid_o),
    .res_step_o   (res_step_o),
    .res_l_col_o  (res_l_col_o),
    .res_u_row_o  (res_u_row_o),
    .res_credit_i (res_credit_i),
    .busy_o       (busy_o),
    .done_o       (done_o)
  );

endmodule

// ==== src/row_store.sv ====
module row_store (
  input  logic                   clk_i,
  input  logic                   rst_ni,

  // host side
  input  logic                   load_valid_i,
  input  lu_ctrl_pkg::row_addr_t load_addr_i,
  input  lu_ctrl_pkg::row_t      load_row_i,

  // engine side
  input  logic                   rd_en_i,
  input  lu_ctrl_pkg::row_addr_t rd_addr_i,
  output lu_ctrl_pkg::row_t      rd_row_o,

  input  logic                   wr_en_i,
  input  lu_ctrl_pkg::row_addr_t wr_addr_i,
  input  lu_ctrl_pkg::row_t      wr_row_i
);

  lu_ctrl_pkg::row_t mem_q [lu_ctrl_pkg::MAT_N];

  always_ff @(posedge clk_i) begin
    if (load_valid_i) mem_q[load_addr_i] <= load_row_i;
    if (wr_en_i) mem_q[wr_addr_i] <= wr_row_i;
  end

  // registered read, sees writes from earlier cycles only
  always_ff @(posedge clk_i) begin
    if (rd_en_i) begin
      rd_row_o <= mem_q[rd_addr_i];
    end
  end

  a_one_writer : assert property (@(posedge clk_i) disable iff (!rst_ni)
    !(load_valid_i && wr_en_i));

endmodule

// ==== lu/lu_step.sv ====
module lu_step (
  input  logic                   clk_i,
  input  logic                   rst_ni,
  input  logic                   start_i,

  output logic                   rd_en_o,
  output lu_ctrl_pkg::row_addr_t rd_addr_o,
  input  lu_ctrl_pkg::row_t      rd_row_i,

  output logic                   wr_en_o,
  output lu_ctrl_pkg::row_addr_t wr_addr_o,
  output lu_ctrl_pkg::row_t      wr_row_o,

  output logic                   res_valid_o,
  output lu_ctrl_pkg::row_addr_t res_step_o,
  output lu_ctrl_pkg::row_t      res_l_col_o,
  output lu_ctrl_pkg::row_t      res_u_row_o,
  input  logic                   res_credit_i,

  output logic                   busy_o,
  output logic                   done_o
);

  lu_ctrl_pkg::lu_state_t state_q;
  lu_ctrl_pkg::row_addr_t k_q, wr_ptr_q, l_ptr_q;
  lu_ctrl_pkg::credit_t   credit_q;

  logic piv_vld_q;  // rd_row_i holds the pivot row
  logic elim_vld_q; // rd_row_i holds a row to eliminate
  logic recip_start_q, recip_done;
  lu_num_pkg::cplx_t recip;

  logic              l_valid;
  lu_num_pkg::cplx_t l_prod;

  logic [lu_ctrl_pkg::MAT_N-1:0] vec_valid;
  lu_ctrl_pkg::row_t             vec_prod;

  lu_ctrl_pkg::row_t u_row_q, l_col_q;
  lu_ctrl_pkg::row_t row_d_q [4]; // rows wait here for their products

  assign res_valid_o = (state_q == lu_ctrl_pkg::EMIT) && (credit_q != '0);
  assign res_step_o  = k_q;
  assign res_l_col_o = l_col_q;
  assign res_u_row_o = u_row_q;

  assign wr_en_o   = &vec_valid;
  assign wr_addr_o = wr_ptr_q;

  always_comb begin
    for (int j = 0; j < lu_ctrl_pkg::MAT_N; j++) begin
      wr_row_o[j][15:0]  = row_d_q[3][j][15:0] - vec_prod[j][15:0];
      wr_row_o[j][31:16] = row_d_q[3][j][31:16] - vec_prod[j][31:16];
    end
  end

  always_ff @(posedge clk_i) begin
    if (!rst_ni) begin
      state_q       <= lu_ctrl_pkg::IDLE;
      k_q           <= '0;
      rd_en_o       <= 1'b0;
      rd_addr_o     <= '0;
      busy_o        <= 1'b0;
      done_o        <= 1'b0;
      recip_start_q <= 1'b0;
      piv_vld_q     <= 1'b0;
      elim_vld_q    <= 1'b0;
      wr_ptr_q      <= '0;
      l_ptr_q       <= '0;
      credit_q      <= lu_ctrl_pkg::credit_t'(lu_ctrl_pkg::RES_CREDITS);
    end else begin
      done_o        <= 1'b0;
      recip_start_q <= 1'b0;
      piv_vld_q     <= rd_en_o && (state_q == lu_ctrl_pkg::PIVOT);
      elim_vld_q    <= rd_en_o && (state_q == lu_ctrl_pkg::ELIM);

      case ({res_valid_o, res_credit_i})
        2'b10:   credit_q <= credit_q - 1'b1;
        2'b01:   credit_q <= credit_q + 1'b1;
        default: ;
      endcase

      if (piv_vld_q) begin
        wr_ptr_q <= k_q + 1'b1;
        l_ptr_q  <= k_q + 1'b1;
      end
      if (wr_en_o) wr_ptr_q <= wr_ptr_q + 1'b1;
      if (l_valid) l_ptr_q <= l_ptr_q + 1'b1;

      case (state_q)
        lu_ctrl_pkg::IDLE: begin
          if (start_i) begin
            state_q   <= lu_ctrl_pkg::PIVOT;
            k_q       <= '0;
            busy_o    <= 1'b1;
            rd_en_o   <= 1'b1;
            rd_addr_o <= '0;
          end
        end
        lu_ctrl_pkg::PIVOT: begin
          rd_en_o <= 1'b0;
          if (piv_vld_q) begin
            if (k_q == lu_ctrl_pkg::MAT_N - 1) state_q <= lu_ctrl_pkg::EMIT;
            else recip_start_q <= 1'b1;
          end
          if (recip_done) begin
            state_q   <= lu_ctrl_pkg::ELIM;
            rd_en_o   <= 1'b1;
            rd_addr_o <= k_q + 1'b1;
          end
        end
        lu_ctrl_pkg::ELIM: begin
          if (rd_addr_o == lu_ctrl_pkg::MAT_N - 1) begin
            rd_en_o <= 1'b0;
            state_q <= lu_ctrl_pkg::DRAIN;
          end else begin
            rd_addr_o <= rd_addr_o + 1'b1;
          end
        end
        lu_ctrl_pkg::DRAIN: begin
          if (wr_en_o && wr_addr_o == lu_ctrl_pkg::MAT_N - 1) state_q <= lu_ctrl_pkg::EMIT;
        end
        lu_ctrl_pkg::EMIT: begin
          if (res_valid_o) begin
            if (k_q == lu_ctrl_pkg::MAT_N - 1) begin
              state_q <= lu_ctrl_pkg::IDLE;
              busy_o  <= 1'b0;
              done_o  <= 1'b1;
            end else begin
              state_q   <= lu_ctrl_pkg::PIVOT;
              k_q       <= k_q + 1'b1;
              rd_en_o   <= 1'b1;
              rd_addr_o <= k_q + 1'b1;
            end
          end
        end
        default: state_q <= lu_ctrl_pkg::IDLE;
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (piv_vld_q) begin
      for (int j = 0; j < lu_ctrl_pkg::MAT_N; j++) begin
        u_row_q[j] <= (j < k_q) ? '0 : rd_row_i[j];
        l_col_q[j] <= (j == k_q) ? lu_num_pkg::CPLX_ONE : '0;
      end
    end
    if (l_valid) l_col_q[l_ptr_q] <= l_prod;
    row_d_q[0] <= rd_row_i;
    for (int s = 1; s < 4; s++) begin
      row_d_q[s] <= row_d_q[s-1];
    end
  end

  complex_recip u_recip (
    .clk_i   (clk_i),
    .rst_ni  (rst_ni),
    .start_i (recip_start_q),
    .pivot_i (u_row_q[k_q]),
    .busy_o  (),
    .done_o  (recip_done),
    .recip_o (recip)
  );

  // l_i = row_i[k] * 1/pivot
  complex_mul u_l_mul (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .in_valid_i  (elim_vld_q),
    .a_i         (rd_row_i[k_q]),
    .b_i         (recip),
    .out_valid_o (l_valid),
    .prod_o      (l_prod)
  );

  for (genvar j = 0; j < lu_ctrl_pkg::MAT_N; j++) begin : g_row_mul
    complex_mul u_row_mul (
      .clk_i       (clk_i),
      .rst_ni      (rst_ni),
      .in_valid_i  (l_valid),
      .a_i         (l_prod),
      .b_i         (u_row_q[j]),
      .out_valid_o (vec_valid[j]),
      .prod_o      (vec_prod[j])
    );
  end

  // consumer must not return more credits than it was given
  a_credit_max : assert property (@(posedge clk_i) disable iff (!rst_ni)
    credit_q <= lu_ctrl_pkg::RES_CREDITS);

endmodule

// ==== lu/complex_recip.sv ====
module complex_recip (
  input  logic              clk_i,
  input  logic              rst_ni,
  input  logic              start_i,
  input  lu_num_pkg::cplx_t pivot_i,
  output logic              busy_o,
  output logic              done_o,
  output lu_num_pkg::cplx_t recip_o
);

  localparam int DEN_W = 32 - lu_num_pkg::FRAC_BITS; // (a^2+b^2) >> frac
  localparam int DIV_W = 16 + lu_num_pkg::FRAC_BITS; // |a| << frac
  localparam int CNT_W = $clog2(DIV_W + 1);

  // {remainder, quotient/dividend} shift register
  function automatic logic [DEN_W+DIV_W-1:0] div_step(input logic [DEN_W+DIV_W-1:0] rq,
                                                      input logic [DEN_W-1:0]       d);
    logic [DEN_W:0]   r_sh;
    logic [DIV_W-1:0] q_sh;
    r_sh = {rq[DEN_W+DIV_W-1:DIV_W], rq[DIV_W-1]};
    q_sh = {rq[DIV_W-2:0], 1'b0};
    if (r_sh >= {1'b0, d}) begin
      r_sh    = r_sh - {1'b0, d};
      q_sh[0] = 1'b1;
    end
    return {r_sh[DEN_W-1:0], q_sh};
  endfunction

  lu_num_pkg::part_t  p_re, p_im;
  logic signed [31:0] sq_re, sq_im;
  logic [31:0]        den_full;
  logic [15:0]        mag_re, mag_im;

  logic [DEN_W-1:0]       den_q;
  logic [DEN_W+DIV_W-1:0] rq_re_q, rq_im_q;
  logic                   neg_re_q, neg_im_q;
  logic [CNT_W-1:0]       cnt_q;
  logic [DIV_W-1:0]       q_re, q_im;
  logic                   last;

  assign p_re     = pivot_i[15:0];
  assign p_im     = pivot_i[31:16];
  assign sq_re    = p_re * p_re;
  assign sq_im    = p_im * p_im;
  assign den_full = $unsigned(sq_re) + $unsigned(sq_im);
  assign mag_re   = p_re[15] ? 16'(-p_re) : p_re; // -32768 still fits unsigned
  assign mag_im   = p_im[15] ? 16'(-p_im) : p_im;

  assign last = busy_o && (cnt_q == CNT_W'(DIV_W));
  assign q_re = rq_re_q[DIV_W-1:0];
  assign q_im = rq_im_q[DIV_W-1:0];

  always_ff @(posedge clk_i) begin
    if (!rst_ni) begin
      busy_o <= 1'b0;
      done_o <= 1'b0;
      cnt_q  <= '0;
    end else begin
      done_o <= 1'b0;
      if (start_i && !busy_o) begin
        busy_o <= 1'b1;
        cnt_q  <= '0;
      end else if (last) begin
        busy_o <= 1'b0;
        done_o <= 1'b1;
      end else if (busy_o) begin
        cnt_q <= cnt_q + 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (start_i && !busy_o) begin
      den_q    <= den_full[31:lu_num_pkg::FRAC_BITS];
      rq_re_q  <= {{DEN_W{1'b0}}, mag_re, {lu_num_pkg::FRAC_BITS{1'b0}}};
      rq_im_q  <= {{DEN_W{1'b0}}, mag_im, {lu_num_pkg::FRAC_BITS{1'b0}}};
      neg_re_q <= p_re[15];
      neg_im_q <= ~p_im[15]; // imaginary numerator is -b
    end else if (busy_o && !last) begin
      rq_re_q <= div_step(rq_re_q, den_q);
      rq_im_q <= div_step(rq_im_q, den_q);
    end
    if (last) begin
      recip_o[15:0]  <= neg_re_q ? 16'(-q_re) : q_re[15:0];
      recip_o[31:16] <= neg_im_q ? 16'(-q_im) : q_im[15:0];
    end
  end

  a_no_restart : assert property (@(posedge clk_i) disable iff (!rst_ni)
    !(start_i && busy_o));

endmodule

// ==== src/complex_mul.sv ====
module complex_mul (
  input  logic              clk_i,
  input  logic              rst_ni,
  input  logic              in_valid_i,
  input  lu_num_pkg::cplx_t a_i,
  input  lu_num_pkg::cplx_t b_i,
  output logic              out_valid_o,
  output lu_num_pkg::cplx_t prod_o
);

  lu_num_pkg::part_t a_re, a_im, b_re, b_im;

  logic signed [31:0] rr_q, ii_q, ri_q, ir_q;
  logic               v1_q;

  logic signed [32:0] re_sum, im_sum;
  logic signed [32:0] re_sh, im_sh;

  assign a_re = a_i[15:0];
  assign a_im = a_i[31:16];
  assign b_re = b_i[15:0];
  assign b_im = b_i[31:16];

  // stage one, partial products
  always_ff @(posedge clk_i) begin
    rr_q <= a_re * b_re;
    ii_q <= a_im * b_im;
    ri_q <= a_re * b_im;
    ir_q <= a_im * b_re;
  end

  // one extra bit so the sums cannot wrap before the shift
  assign re_sum = rr_q - ii_q;
  assign im_sum = ri_q + ir_q;
  assign re_sh  = re_sum >>> lu_num_pkg::FRAC_BITS; // floor
  assign im_sh  = im_sum >>> lu_num_pkg::FRAC_BITS;

  // stage two
  always_ff @(posedge clk_i) begin
    prod_o <= {im_sh[15:0], re_sh[15:0]};
  end

  always_ff @(posedge clk_i) begin
    if (!rst_ni) begin
      v1_q        <= 1'b0;
      out_valid_o <= 1'b0;
    end else begin
      v1_q        <= in_valid_i;
      out_valid_o <= v1_q;
    end
  end

endmodule

// ==== common/lu_ctrl_pkg.sv ====
package lu_ctrl_pkg;

  localparam int MAT_N = 4;

  typedef logic [$clog2(MAT_N)-1:0] row_addr_t;

  // element 0 in the low bits
  typedef lu_num_pkg::cplx_t [MAT_N-1:0] row_t;

  // credits on the result stream
  localparam int RES_CREDITS = 2;
  typedef logic [1:0] credit_t;

  typedef enum logic [2:0] {
    IDLE,
    PIVOT, // row read and reciprocal
    ELIM,
    DRAIN, // wait for last write-back
    EMIT
  } lu_state_t;

endpackage

// ==== common/lu_num_pkg.sv ====
package lu_num_pkg;

  localparam int PART_W = 16;
  localparam int FRAC_BITS = 12; // q3.12

  // one real or imaginary part
  typedef logic signed [PART_W-1:0] part_t;

  // {im, re}
  typedef logic [2*PART_W-1:0] cplx_t;

  localparam cplx_t CPLX_ONE = {{PART_W{1'b0}}, part_t'(1 << FRAC_BITS)};

endpackage
